//--- src/riscv_csr_pkg.sv
package riscv_csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [11:0] csr_addr_t;   // csr number
  typedef logic [31:0] csr_data_t;   // csr data word
  typedef logic [5:0]  exc_cause_t;  // bit 5 marks an interrupt
  typedef logic [3:0]  core_id_t;
  typedef logic [5:0]  cluster_id_t;

  // csr operation, same encoding as the csr instruction funct bits
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,  // plain read
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // csr address map
  ////////////////////////////////////////////////////////////

  // machine mode registers
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MHARTID  = 12'hF14;  // read only

  // performance counters, read only
  localparam csr_addr_t CSR_PCCR_INSTR = 12'h781;  // retired instructions
  localparam csr_addr_t CSR_PCCR_LOAD  = 12'h782;  // granted loads
  localparam csr_addr_t CSR_PCCR_STORE = 12'h783;  // granted stores

  // global interrupt enable inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT = 3;

endpackage

//--- src/riscv_dbg_pkg.sv
package riscv_dbg_pkg;

  typedef logic [14:0] dbg_addr_t;  // debug bus address

  ////////////////////////////////////////////////////////////
  // debug bus address map
  ////////////////////////////////////////////////////////////

  // bit 14 set selects csr space, csr number in bits 13:2
  localparam int unsigned DBG_CSR_SEL_BIT = 14;

  // control space, everything else reads zero
  localparam dbg_addr_t   DBG_CTRL_ADDR     = 15'h0000;
  localparam int unsigned DBG_CTRL_HALT_BIT = 0;  // halt flag in ctrl reg

  // halt state machine
  typedef enum logic {
    DBG_RUNNING = 1'b0,
    DBG_HALTED  = 1'b1
  } dbg_state_e;

endpackage

//--- src/riscv_csr_arbiter.sv
`timescale 1ns/10ps

module riscv_csr_arbiter
  import riscv_csr_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  // core side, from ex stage
  input  logic      core_access_i,
  input  csr_op_e   core_op_i,
  input  csr_addr_t core_addr_i,
  input  csr_data_t core_wdata_i,
  output logic      core_rvalid_o,
  output csr_data_t core_rdata_o,

  // debug side, always wins
  input  logic      dbg_req_i,
  input  logic      dbg_we_i,
  input  csr_addr_t dbg_addr_i,
  input  csr_data_t dbg_wdata_i,
  output logic      dbg_rvalid_o,
  output csr_data_t dbg_rdata_o,

  // towards the register file
  output logic      rf_access_o,
  output csr_op_e   rf_op_o,
  output csr_addr_t rf_addr_o,
  output csr_data_t rf_wdata_o,
  input  csr_data_t rf_rdata_i   // registered, one cycle after issue
);

  // one-entry hold for a core access that lost to debug
  logic      hold_valid_q;
  csr_op_e   hold_op_q;
  csr_addr_t hold_addr_q;
  csr_data_t hold_wdata_q;
  logic      hold_load;

  logic      issue_dbg;
  logic      issue_hold;
  logic      issue_core;
  csr_op_e   dbg_op;

  // who got the rf last cycle
  logic      issued_q;
  logic      owner_dbg_q;

  ////////////////////////////////////////////////////////////
  // issue selection
  ////////////////////////////////////////////////////////////

  assign dbg_op     = dbg_we_i ? CSR_OP_WRITE : CSR_OP_NONE;  // debug only reads or writes
  assign issue_dbg  = dbg_req_i;
  assign issue_hold = hold_valid_q & ~dbg_req_i;                  // held access next in line
  assign issue_core = core_access_i & ~dbg_req_i & ~hold_valid_q;
  assign hold_load  = core_access_i & ~issue_core;                // core lost this cycle

  always_comb begin
    rf_access_o = issue_dbg | issue_hold | issue_core;
    if (issue_dbg) begin
      rf_op_o    = dbg_op;
      rf_addr_o  = dbg_addr_i;
      rf_wdata_o = dbg_wdata_i;
    end else if (issue_hold) begin
      rf_op_o    = hold_op_q;
      rf_addr_o  = hold_addr_q;
      rf_wdata_o = hold_wdata_q;
    end else begin
      rf_op_o    = core_op_i;  // also the idle value
      rf_addr_o  = core_addr_i;
      rf_wdata_o = core_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // hold entry and owner tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_valid_q <= 1'b0;
      issued_q     <= 1'b0;
      owner_dbg_q  <= 1'b0;
    end else begin
      hold_valid_q <= hold_load | (hold_valid_q & ~issue_hold);
      issued_q     <= rf_access_o;
      owner_dbg_q  <= issue_dbg;
    end
  end

  // payload of the held access
  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      hold_op_q    <= core_op_i;
      hold_addr_q  <= core_addr_i;
      hold_wdata_q <= core_wdata_i;
    end
  end

  // route read data back to whoever issued last cycle
  assign core_rvalid_o = issued_q & ~owner_dbg_q;
  assign dbg_rvalid_o  = issued_q & owner_dbg_q;
  assign core_rdata_o  = core_rvalid_o ? rf_rdata_i : '0;
  assign dbg_rdata_o   = dbg_rvalid_o ? rf_rdata_i : '0;

endmodule

//--- src/riscv_cs_registers.sv
`timescale 1ns/10ps

module riscv_cs_registers
  import riscv_csr_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,

  // single access port, from the arbiter
  input  logic        access_i,
  input  csr_op_e     op_i,
  input  csr_addr_t   addr_i,
  input  csr_data_t   wdata_i,
  output csr_data_t   rdata_o,   // valid the cycle after access_i

  // static ids for mhartid
  input  core_id_t    core_id_i,
  input  cluster_id_t cluster_id_i,

  // exception save
  input  logic        exc_save_i,
  input  csr_data_t   exc_pc_i,
  input  exc_cause_t  exc_cause_i,

  // counter values
  input  csr_data_t   cnt_instr_i,
  input  csr_data_t   cnt_load_i,
  input  csr_data_t   cnt_store_i,

  output logic        irq_enable_o,
  output csr_data_t   mepc_o
);

  logic       mie_q;       // mstatus.MIE
  csr_data_t  mscratch_q;
  csr_data_t  mepc_q;
  exc_cause_t mcause_q;

  csr_data_t  rdata_int;   // current value at addr_i
  csr_data_t  wdata_int;   // value after the operation
  csr_data_t  rdata_q;
  logic       csr_we;

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_int = '0;  // unknown addresses read zero
    case (addr_i)
      CSR_MSTATUS:    rdata_int[MSTATUS_MIE_BIT] = mie_q;
      CSR_MSCRATCH:   rdata_int = mscratch_q;
      CSR_MEPC:       rdata_int = mepc_q;
      CSR_MCAUSE:     rdata_int = {mcause_q[5], 26'b0, mcause_q[4:0]};  // irq flag on top
      CSR_MHARTID:    rdata_int = {21'b0, cluster_id_i, 1'b0, core_id_i};
      CSR_PCCR_INSTR: rdata_int = cnt_instr_i;
      CSR_PCCR_LOAD:  rdata_int = cnt_load_i;
      CSR_PCCR_STORE: rdata_int = cnt_store_i;
      default:        rdata_int = '0;
    endcase
  end

  // write, set and clear all work on the old value
  always_comb begin
    case (op_i)
      CSR_OP_WRITE: wdata_int = wdata_i;
      CSR_OP_SET:   wdata_int = rdata_int | wdata_i;
      CSR_OP_CLEAR: wdata_int = rdata_int & ~wdata_i;
      default:      wdata_int = rdata_int;
    endcase
  end

  assign csr_we = access_i & (op_i != CSR_OP_NONE);

  ////////////////////////////////////////////////////////////
  // register update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q      <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (csr_we) begin
        case (addr_i)
          CSR_MSTATUS:  mie_q      <= wdata_int[MSTATUS_MIE_BIT];
          CSR_MSCRATCH: mscratch_q <= wdata_int;
          CSR_MEPC:     mepc_q     <= wdata_int;
          CSR_MCAUSE:   mcause_q   <= {wdata_int[31], wdata_int[4:0]};
          default: ;    // read only or unmapped
        endcase
      end
      // exception entry overrides a csr write in the same cycle
      if (exc_save_i) begin
        mie_q    <= 1'b0;  // irqs off on entry
        mepc_q   <= exc_pc_i;
        mcause_q <= exc_cause_i;
      end
    end
  end

  // read data holds the pre-update value
  always_ff @(posedge clk_i) begin
    if (access_i) begin
      rdata_q <= rdata_int;
    end
  end

  assign rdata_o      = rdata_q;
  assign irq_enable_o = mie_q;
  assign mepc_o       = mepc_q;

endmodule

//--- src/riscv_perf_counters.sv
`timescale 1ns/10ps

module riscv_perf_counters
  import riscv_csr_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  input  logic      halted_i,         // freezes all counters

  // event sources
  input  logic      instr_retired_i,
  input  logic      data_req_i,       // observed data bus
  input  logic      data_gnt_i,
  input  logic      data_we_i,

  output csr_data_t cnt_instr_o,
  output csr_data_t cnt_load_o,
  output csr_data_t cnt_store_o
);

  localparam int unsigned N_CNT = 3;

  logic [N_CNT-1:0] event_vec;  // one bit per counter
  csr_data_t        cnt_q [N_CNT];
  logic             mem_xfer;

  // a transfer only happens on grant
  assign mem_xfer     = data_req_i & data_gnt_i;
  assign event_vec[0] = instr_retired_i;
  assign event_vec[1] = mem_xfer & ~data_we_i;  // load
  assign event_vec[2] = mem_xfer & data_we_i;   // store

  ////////////////////////////////////////////////////////////
  // counters, 32 bit wrapping
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else if (!halted_i) begin
      for (int i = 0; i < N_CNT; i++) begin
        if (event_vec[i]) cnt_q[i] <= cnt_q[i] + 32'd1;  // wraps at 2^32
      end
    end
  end

  assign cnt_instr_o = cnt_q[0];
  assign cnt_load_o  = cnt_q[1];
  assign cnt_store_o = cnt_q[2];

endmodule

//--- src/riscv_debug_unit.sv
`timescale 1ns/10ps

module riscv_debug_unit
  import riscv_csr_pkg::*;
  import riscv_dbg_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,

  // debug bus, every request accepted
  input  logic      debug_req_i,
  input  dbg_addr_t debug_addr_i,
  input  logic      debug_we_i,
  input  csr_data_t debug_wdata_i,
  output logic      debug_rvalid_o,
  output csr_data_t debug_rdata_o,

  // halt control pins
  input  logic      debug_halt_i,
  input  logic      debug_resume_i,
  output logic      debug_halted_o,

  // csr port towards the arbiter
  output logic      csr_req_o,
  output logic      csr_we_o,
  output csr_addr_t csr_addr_o,
  output csr_data_t csr_wdata_o,
  input  logic      csr_rvalid_i,
  input  csr_data_t csr_rdata_i
);

  logic       csr_sel;      // address in csr space
  logic       ctrl_hit;     // debug control register hit
  logic       ctrl_wr;
  logic       halt_set;
  logic       halt_clr;
  logic       ctrl_rvalid_q;
  csr_data_t  ctrl_rdata_q;
  csr_data_t  ctrl_rdata_d;
  dbg_state_e state_q, state_d;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  assign csr_sel     = debug_addr_i[DBG_CSR_SEL_BIT];
  assign csr_req_o   = debug_req_i & csr_sel;
  assign csr_we_o    = debug_we_i;
  assign csr_addr_o  = debug_addr_i[DBG_CSR_SEL_BIT-1:2];  // word address to csr number
  assign csr_wdata_o = debug_wdata_i;

  assign ctrl_hit = debug_req_i & ~csr_sel & (debug_addr_i == DBG_CTRL_ADDR);
  assign ctrl_wr  = ctrl_hit & debug_we_i;

  // halt requests from pins or the ctrl register
  assign halt_set = debug_halt_i | (ctrl_wr & debug_wdata_i[DBG_CTRL_HALT_BIT]);
  assign halt_clr = debug_resume_i | (ctrl_wr & ~debug_wdata_i[DBG_CTRL_HALT_BIT]);

  ////////////////////////////////////////////////////////////
  // halt fsm
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      DBG_RUNNING: if (halt_set) state_d = DBG_HALTED;
      DBG_HALTED:  if (halt_clr && !halt_set) state_d = DBG_RUNNING;  // halt wins
      default:     state_d = DBG_RUNNING;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= DBG_RUNNING;
      ctrl_rvalid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      ctrl_rvalid_q <= debug_req_i & ~csr_sel;  // any non-csr access answers
    end
  end

  assign debug_halted_o = (state_q == DBG_HALTED);

  // ctrl read returns halt state seen during the request
  always_comb begin
    ctrl_rdata_d = '0;
    if (ctrl_hit) ctrl_rdata_d[DBG_CTRL_HALT_BIT] = debug_halted_o;
  end

  always_ff @(posedge clk_i) begin
    ctrl_rdata_q <= ctrl_rdata_d;
  end

  // response, csr data forwarded as it comes back
  assign debug_rvalid_o = ctrl_rvalid_q | csr_rvalid_i;
  assign debug_rdata_o  = csr_rvalid_i ? csr_rdata_i : ctrl_rdata_q;

endmodule

//--- src/riscv_csr_subsystem.sv
`timescale 1ns/10ps

module riscv_csr_subsystem
  import riscv_csr_pkg::*;
  import riscv_dbg_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,

  input  core_id_t    core_id_i,
  input  cluster_id_t cluster_id_i,

  // core csr port
  input  logic        csr_access_i,
  input  csr_op_e     csr_op_i,
  input  csr_addr_t   csr_addr_i,
  input  csr_data_t   csr_wdata_i,
  output logic        core_csr_rvalid_o,
  output csr_data_t   core_csr_rdata_o,

  // events and exceptions
  input  logic        instr_retired_i,
  input  logic        data_req_i,
  input  logic        data_gnt_i,
  input  logic        data_we_i,
  input  logic        exc_save_i,
  input  csr_data_t   exc_pc_i,
  input  exc_cause_t  exc_cause_i,

  // debug bus
  input  logic        debug_req_i,
  input  dbg_addr_t   debug_addr_i,
  input  logic        debug_we_i,
  input  csr_data_t   debug_wdata_i,
  output logic        debug_rvalid_o,
  output csr_data_t   debug_rdata_o,
  input  logic        debug_halt_i,
  input  logic        debug_resume_i,
  output logic        debug_halted_o,

  output logic        irq_enable_o,
  output csr_data_t   mepc_o
);

  // debug unit to arbiter
  logic      dbg_csr_req;
  logic      dbg_csr_we;
  csr_addr_t dbg_csr_addr;
  csr_data_t dbg_csr_wdata;
  logic      dbg_csr_rvalid;
  csr_data_t dbg_csr_rdata;

  // arbiter to register file
  logic      rf_access;
  csr_op_e   rf_op;
  csr_addr_t rf_addr;
  csr_data_t rf_wdata;
  csr_data_t rf_rdata;

  csr_data_t cnt_instr;
  csr_data_t cnt_load;
  csr_data_t cnt_store;
  logic      halted;

  assign debug_halted_o = halted;

  ////////////////////////////////////////////////////////////
  // csr access arbitration
  ////////////////////////////////////////////////////////////

  riscv_csr_arbiter csr_arbiter_i (
    .clk_i         ( clk_i             ),
    .arst_n_i      ( arst_n_i          ),
    .core_access_i ( csr_access_i      ),
    .core_op_i     ( csr_op_i          ),
    .core_addr_i   ( csr_addr_i        ),
    .core_wdata_i  ( csr_wdata_i       ),
    .core_rvalid_o ( core_csr_rvalid_o ),
    .core_rdata_o  ( core_csr_rdata_o  ),
    .dbg_req_i     ( dbg_csr_req       ),
    .dbg_we_i      ( dbg_csr_we        ),
    .dbg_addr_i    ( dbg_csr_addr      ),
    .dbg_wdata_i   ( dbg_csr_wdata     ),
    .dbg_rvalid_o  ( dbg_csr_rvalid    ),
    .dbg_rdata_o   ( dbg_csr_rdata     ),
    .rf_access_o   ( rf_access         ),
    .rf_op_o       ( rf_op             ),
    .rf_addr_o     ( rf_addr           ),
    .rf_wdata_o    ( rf_wdata          ),
    .rf_rdata_i    ( rf_rdata          )
  );

  riscv_cs_registers cs_registers_i (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .access_i     ( rf_access    ),
    .op_i         ( rf_op        ),
    .addr_i       ( rf_addr      ),
    .wdata_i      ( rf_wdata     ),
    .rdata_o      ( rf_rdata     ),
    .core_id_i    ( core_id_i    ),
    .cluster_id_i ( cluster_id_i ),
    .exc_save_i   ( exc_save_i   ),
    .exc_pc_i     ( exc_pc_i     ),
    .exc_cause_i  ( exc_cause_i  ),
    .cnt_instr_i  ( cnt_instr    ),
    .cnt_load_i   ( cnt_load     ),
    .cnt_store_i  ( cnt_store    ),
    .irq_enable_o ( irq_enable_o ),
    .mepc_o       ( mepc_o       )
  );

  ////////////////////////////////////////////////////////////
  // counters and debug
  ////////////////////////////////////////////////////////////

  riscv_perf_counters perf_counters_i (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .halted_i        ( halted          ),  // frozen in debug halt
    .instr_retired_i ( instr_retired_i ),
    .data_req_i      ( data_req_i      ),
    .data_gnt_i      ( data_gnt_i      ),
    .data_we_i       ( data_we_i       ),
    .cnt_instr_o     ( cnt_instr       ),
    .cnt_load_o      ( cnt_load        ),
    .cnt_store_o     ( cnt_store       )
  );

  riscv_debug_unit debug_unit_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .debug_req_i    ( debug_req_i    ),
    .debug_addr_i   ( debug_addr_i   ),
    .debug_we_i     ( debug_we_i     ),
    .debug_wdata_i  ( debug_wdata_i  ),
    .debug_rvalid_o ( debug_rvalid_o ),
    .debug_rdata_o  ( debug_rdata_o  ),
    .debug_halt_i   ( debug_halt_i   ),
    .debug_resume_i ( debug_resume_i ),
    .debug_halted_o ( halted         ),
    .csr_req_o      ( dbg_csr_req    ),
    .csr_we_o       ( dbg_csr_we     ),
    .csr_addr_o     ( dbg_csr_addr   ),
    .csr_wdata_o    ( dbg_csr_wdata  ),
    .csr_rvalid_i   ( dbg_csr_rvalid ),
    .csr_rdata_i    ( dbg_csr_rdata  )
  );

endmodule

//--- bench/riscv_csr_subsystem_properties.sv
`timescale 1ns/10ps

module riscv_csr_subsystem_properties (
  input logic clk_i,
  input logic arst_n_i,
  input logic core_access_i,
  input logic dbg_req_i,
  input logic core_rvalid_o,
  input logic dbg_rvalid_o
);

  // debug csr strobes never back to back
  dbg_spacing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dbg_req_i |=> !dbg_req_i)
    else $error("debug strobe on consecutive cycles");

  // core strobes at least two cycles apart
  core_spacing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_access_i |=> !core_access_i)
    else $error("core strobes closer than two cycles");

  // debug strobe answered next cycle, debug side only
  dbg_response: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dbg_req_i |=> (dbg_rvalid_o && !core_rvalid_o))
    else $error("debug strobe without its rvalid one cycle later");

  // core strobe with no collision answered next cycle
  core_response: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (core_access_i && !dbg_req_i) |=> (core_rvalid_o && !dbg_rvalid_o))
    else $error("core strobe without its rvalid one cycle later");

  // colliding core strobe held, no answer yet
  held_wait: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (core_access_i && dbg_req_i) |=> !core_rvalid_o)
    else $error("held core access answered too early");

  held_response: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(core_access_i && dbg_req_i) |=> core_rvalid_o)
    else $error("held core access not answered two cycles after its strobe");

  // rvalid only for a strobe that was issued
  core_no_stray: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_rvalid_o |-> ($past(core_access_i && !dbg_req_i) ||
                       $past(core_access_i && dbg_req_i, 2)))
    else $error("core rvalid without an issued access");

  dbg_no_stray: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dbg_rvalid_o |-> $past(dbg_req_i))
    else $error("debug rvalid without an issued access");

endmodule

bind riscv_csr_arbiter riscv_csr_subsystem_properties i_props (.*);

//--- bench/riscv_csr_subsystem_tb.sv
`timescale 1ns/10ps

module riscv_csr_subsystem_tb
  import riscv_csr_pkg::*;
  import riscv_dbg_pkg::*;
;

  localparam int unsigned N_RAND       = 300;
  localparam int unsigned N_DIRECTED   = 73;   // reset plus directed test cycles
  localparam int unsigned TOTAL_CYCLES = N_RAND + N_DIRECTED;

  logic        clk_i;
  logic        arst_n_i;
  core_id_t    core_id_i;
  cluster_id_t cluster_id_i;
  logic        csr_access_i;
  csr_op_e     csr_op_i;
  csr_addr_t   csr_addr_i;
  csr_data_t   csr_wdata_i;
  logic        core_csr_rvalid_o;
  csr_data_t   core_csr_rdata_o;
  logic        instr_retired_i;
  logic        data_req_i;
  logic        data_gnt_i;
  logic        data_we_i;
  logic        exc_save_i;
  csr_data_t   exc_pc_i;
  exc_cause_t  exc_cause_i;
  logic        debug_req_i;
  dbg_addr_t   debug_addr_i;
  logic        debug_we_i;
  csr_data_t   debug_wdata_i;
  logic        debug_rvalid_o;
  csr_data_t   debug_rdata_o;
  logic        debug_halt_i;
  logic        debug_resume_i;
  logic        debug_halted_o;
  logic        irq_enable_o;
  csr_data_t   mepc_o;

  // shadow model state
  logic        m_mie;
  csr_data_t   m_mscratch;
  csr_data_t   m_mepc;
  exc_cause_t  m_mcause;
  csr_data_t   m_cnt [3];
  logic        m_halted;
  logic        m_hold_v;
  csr_op_e     m_hold_op;
  csr_addr_t   m_hold_addr;
  csr_data_t   m_hold_wdata;
  logic        exp_core_v;
  csr_data_t   exp_core_d;
  logic        exp_dbg_v;
  csr_data_t   exp_dbg_d;

  logic [31:0] lfsr_q;
  logic        core_prev;
  logic        dbg_prev;
  string       test_name;
  int          test_errs;
  int          total_errs;
  int          n_tests;
  int          n_checks;

  riscv_csr_subsystem i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // watchdog
  initial begin
    #(TOTAL_CYCLES * 20 + 500);
    $display("timeout: the tests did not finish in time");
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // random source, fibonacci lfsr taps 32 22 2 1
  ////////////////////////////////////////////////////////////

  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function csr_addr_t pick_addr(input logic [2:0] sel);
    case (sel)
      3'd0:    return CSR_MSTATUS;
      3'd1:    return CSR_MSCRATCH;
      3'd2:    return CSR_MEPC;
      3'd3:    return CSR_MCAUSE;
      3'd4:    return CSR_MHARTID;
      3'd5:    return CSR_PCCR_INSTR;
      3'd6:    return CSR_PCCR_LOAD;
      default: return CSR_PCCR_STORE;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // shadow model
  ////////////////////////////////////////////////////////////

  function csr_data_t model_read(input csr_addr_t a);
    case (a)
      CSR_MSTATUS:    return {28'b0, m_mie, 3'b0};
      CSR_MSCRATCH:   return m_mscratch;
      CSR_MEPC:       return m_mepc;
      CSR_MCAUSE:     return {m_mcause[5], 26'b0, m_mcause[4:0]};
      CSR_MHARTID:    return {21'b0, cluster_id_i, 1'b0, core_id_i};
      CSR_PCCR_INSTR: return m_cnt[0];
      CSR_PCCR_LOAD:  return m_cnt[1];
      CSR_PCCR_STORE: return m_cnt[2];
      default:        return '0;
    endcase
  endfunction

  task model_reset;
    m_mie      = 1'b0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_halted   = 1'b0;
    m_hold_v   = 1'b0;
    exp_core_v = 1'b0;
    exp_dbg_v  = 1'b0;
    for (int i = 0; i < 3; i++) m_cnt[i] = '0;
  endtask

  // one clock edge worth of rules, using this cycle's inputs
  task model_step;
    logic      dcsr;
    logic      iss;
    logic      to_dbg;
    logic      ctrl_wr;
    logic      hset;
    logic      hclr;
    csr_op_e   op;
    csr_addr_t a;
    csr_data_t wd;
    csr_data_t old;
    csr_data_t nv;
    dcsr    = debug_req_i & debug_addr_i[14];
    iss     = 1'b1;
    to_dbg  = 1'b0;
    op      = CSR_OP_NONE;
    a       = '0;
    wd      = '0;
    if (dcsr) begin  // debug first
      op     = debug_we_i ? CSR_OP_WRITE : CSR_OP_NONE;
      a      = debug_addr_i[13:2];
      wd     = debug_wdata_i;
      to_dbg = 1'b1;
    end else if (m_hold_v) begin
      op = m_hold_op;
      a  = m_hold_addr;
      wd = m_hold_wdata;
    end else if (csr_access_i) begin
      op = csr_op_i;
      a  = csr_addr_i;
      wd = csr_wdata_i;
    end else begin
      iss = 1'b0;
    end
    if (dcsr && csr_access_i) begin  // core loses, held one cycle
      m_hold_op    = csr_op_i;
      m_hold_addr  = csr_addr_i;
      m_hold_wdata = csr_wdata_i;
    end
    m_hold_v = dcsr & (csr_access_i | m_hold_v);

    old        = model_read(a);
    exp_core_v = iss & ~to_dbg;
    exp_core_d = old;
    exp_dbg_v  = (iss & to_dbg) | (debug_req_i & ~debug_addr_i[14]);
    exp_dbg_d  = to_dbg ? old :
                 (debug_addr_i == '0) ? {31'b0, m_halted} : '0;

    if (iss && op != CSR_OP_NONE) begin
      case (op)
        CSR_OP_WRITE: nv = wd;
        CSR_OP_SET:   nv = old | wd;
        default:      nv = old & ~wd;
      endcase
      case (a)
        CSR_MSTATUS:  m_mie      = nv[3];
        CSR_MSCRATCH: m_mscratch = nv;
        CSR_MEPC:     m_mepc     = nv;
        CSR_MCAUSE:   m_mcause   = {nv[31], nv[4:0]};
        default: ;
      endcase
    end
    if (exc_save_i) begin  // beats the csr write
      m_mie    = 1'b0;
      m_mepc   = exc_pc_i;
      m_mcause = exc_cause_i;
    end
    if (!m_halted) begin
      if (instr_retired_i) m_cnt[0] = m_cnt[0] + 1;
      if (data_req_i && data_gnt_i && !data_we_i) m_cnt[1] = m_cnt[1] + 1;
      if (data_req_i && data_gnt_i && data_we_i) m_cnt[2] = m_cnt[2] + 1;
    end
    ctrl_wr = debug_req_i & debug_we_i & (debug_addr_i == '0);
    hset    = debug_halt_i | (ctrl_wr & debug_wdata_i[0]);
    hclr    = debug_resume_i | (ctrl_wr & ~debug_wdata_i[0]);
    if (hset) m_halted = 1'b1;
    else if (hclr) m_halted = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task value_error(input string what, input csr_data_t exp, input csr_data_t act);
    $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
    test_errs++;
  endtask

  task check_outputs;
    n_checks++;
    if (core_csr_rvalid_o !== exp_core_v) begin
      $display("%s: core rvalid was %b but %b was due", test_name, core_csr_rvalid_o,
               exp_core_v);
      test_errs++;
    end else if (exp_core_v && core_csr_rdata_o !== exp_core_d) begin
      value_error("core rdata", exp_core_d, core_csr_rdata_o);
    end
    if (debug_rvalid_o !== exp_dbg_v) begin
      $display("%s: debug rvalid was %b but %b was due", test_name, debug_rvalid_o,
               exp_dbg_v);
      test_errs++;
    end else if (exp_dbg_v && debug_rdata_o !== exp_dbg_d) begin
      value_error("debug rdata", exp_dbg_d, debug_rdata_o);
    end
    if (debug_halted_o !== m_halted) begin
      value_error("halted", 32'(m_halted), 32'(debug_halted_o));
    end
    if (irq_enable_o !== m_mie) begin
      value_error("irq_enable", 32'(m_mie), 32'(irq_enable_o));
    end
    if (mepc_o !== m_mepc) value_error("mepc_o", m_mepc, mepc_o);
  endtask

  task idle_inputs;
    csr_access_i    = 1'b0;
    csr_op_i        = CSR_OP_NONE;
    csr_addr_i      = '0;
    csr_wdata_i     = '0;
    debug_req_i     = 1'b0;
    debug_addr_i    = '0;
    debug_we_i      = 1'b0;
    debug_wdata_i   = '0;
    debug_halt_i    = 1'b0;
    debug_resume_i  = 1'b0;
    instr_retired_i = 1'b0;
    data_req_i      = 1'b0;
    data_gnt_i      = 1'b0;
    data_we_i       = 1'b0;
    exc_save_i      = 1'b0;
    exc_pc_i        = '0;
    exc_cause_i     = '0;
  endtask

  // edge, model, sample at +1, new inputs at +2
  task cycle;
    @(posedge clk_i);
    if (arst_n_i) model_step();
    else model_reset();
    #1;
    if (arst_n_i) check_outputs();
    core_prev = csr_access_i;
    dbg_prev  = debug_req_i;
    #1;
    idle_inputs();
  endtask

  task core_cmd(input csr_op_e op, input csr_addr_t a, input csr_data_t wd);
    csr_access_i = 1'b1;
    csr_op_i     = op;
    csr_addr_i   = a;
    csr_wdata_i  = wd;
    cycle();
    cycle();
  endtask

  task dbg_cmd(input dbg_addr_t a, input logic we, input csr_data_t wd);
    debug_req_i   = 1'b1;
    debug_addr_i  = a;
    debug_we_i    = we;
    debug_wdata_i = wd;
    cycle();
    cycle();
  endtask

  function dbg_addr_t csr_space(input csr_addr_t a);
    return {1'b1, a, 2'b00};
  endfunction

  task random_events;
    instr_retired_i = 1'(rand_bits(1));
    data_req_i      = 1'(rand_bits(1));
    data_gnt_i      = 1'(rand_bits(1));
    data_we_i       = 1'(rand_bits(1));
  endtask

  task start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task end_test;
    n_tests++;
    total_errs += test_errs;
    $display("test %s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "FAIL",
             test_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr_q       = 32'he35f3ad4;
    arst_n_i     = 1'b0;
    core_id_i    = 4'h5;
    cluster_id_i = 6'h2a;
    core_prev    = 1'b0;
    dbg_prev     = 1'b0;
    total_errs   = 0;
    n_tests      = 0;
    n_checks     = 0;
    test_name    = "reset";
    idle_inputs();
    model_reset();
    repeat (5) cycle();
    arst_n_i = 1'b1;

    start_test("core_ops");
    core_cmd(CSR_OP_WRITE, CSR_MSCRATCH, 32'ha5a5_1234);
    core_cmd(CSR_OP_SET, CSR_MSCRATCH, 32'h0f00_000f);
    core_cmd(CSR_OP_CLEAR, CSR_MSCRATCH, 32'h0000_ffff);
    core_cmd(CSR_OP_NONE, CSR_MSCRATCH, '0);
    core_cmd(CSR_OP_SET, CSR_MSTATUS, 32'h8);  // irq on
    core_cmd(CSR_OP_WRITE, CSR_MEPC, 32'h8000_0100);
    core_cmd(CSR_OP_CLEAR, CSR_MSTATUS, 32'hffff_ffff);
    core_cmd(CSR_OP_NONE, CSR_MEPC, '0);
    end_test();

    start_test("exception");
    core_cmd(CSR_OP_SET, CSR_MSTATUS, 32'h8);
    exc_save_i  = 1'b1;
    exc_pc_i    = 32'h0000_2468;
    exc_cause_i = 6'h2b;
    core_cmd(CSR_OP_WRITE, CSR_MEPC, 32'hdead_beef);  // loses to the save
    core_cmd(CSR_OP_NONE, CSR_MCAUSE, '0);
    core_cmd(CSR_OP_NONE, CSR_MEPC, '0);
    end_test();

    start_test("collision");
    csr_access_i = 1'b1;
    csr_op_i     = CSR_OP_NONE;
    csr_addr_i   = CSR_MSCRATCH;
    dbg_cmd(csr_space(CSR_MSCRATCH), 1'b1, 32'h1357_9bdf);
    cycle();
    csr_access_i = 1'b1;
    csr_op_i     = CSR_OP_WRITE;
    csr_addr_i   = CSR_MEPC;
    csr_wdata_i  = 32'h0000_4000;
    dbg_cmd(csr_space(CSR_MEPC), 1'b0, '0);
    cycle();
    end_test();

    start_test("random_mix");
    for (int i = 0; i < N_RAND; i++) begin
      random_events();
      if (!core_prev && rand_bits(2) == 0) begin
        csr_access_i = 1'b1;
        csr_op_i     = csr_op_e'(2'(rand_bits(2)));
        csr_addr_i   = pick_addr(3'(rand_bits(3)));
        csr_wdata_i  = rand_bits(32);
      end
      if (!dbg_prev && rand_bits(2) == 0) begin
        debug_req_i   = 1'b1;
        debug_addr_i  = csr_space(pick_addr(3'(rand_bits(3))));
        debug_we_i    = 1'(rand_bits(1));
        debug_wdata_i = rand_bits(32);
      end
      if (rand_bits(4) == 0) begin  // rare exception
        exc_save_i  = 1'b1;
        exc_pc_i    = rand_bits(32);
        exc_cause_i = 6'(rand_bits(6));
      end
      cycle();
    end
    cycle();
    end_test();

    start_test("halt_resume");
    debug_halt_i = 1'b1;
    random_events();
    cycle();
    for (int i = 0; i < 6; i++) begin
      random_events();
      cycle();
    end
    core_cmd(CSR_OP_NONE, CSR_PCCR_INSTR, '0);
    debug_halt_i   = 1'b1;
    debug_resume_i = 1'b1;  // halt wins
    cycle();
    debug_resume_i = 1'b1;
    cycle();
    dbg_cmd(DBG_CTRL_ADDR, 1'b1, 32'h1);
    dbg_cmd(DBG_CTRL_ADDR, 1'b0, '0);
    random_events();
    cycle();
    dbg_cmd(DBG_CTRL_ADDR, 1'b1, 32'h0);
    random_events();
    cycle();
    core_cmd(CSR_OP_NONE, CSR_PCCR_LOAD, '0);
    end_test();

    start_test("debug_csr");
    dbg_cmd(csr_space(CSR_MHARTID), 1'b0, '0);
    dbg_cmd(csr_space(12'h123), 1'b0, '0);
    dbg_cmd(csr_space(CSR_MHARTID), 1'b1, 32'hffff_ffff);
    dbg_cmd(csr_space(CSR_PCCR_STORE), 1'b1, 32'h5555_5555);
    dbg_cmd(csr_space(CSR_MHARTID), 1'b0, '0);
    dbg_cmd(csr_space(CSR_PCCR_STORE), 1'b0, '0);
    dbg_cmd(15'h0004, 1'b1, 32'h1);  // unmapped ctrl space
    dbg_cmd(15'h0004, 1'b0, '0);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, total_errs);
    if (total_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- riscv_csr_subsystem.f
src/riscv_csr_pkg.sv
src/riscv_dbg_pkg.sv
src/riscv_csr_arbiter.sv
src/riscv_cs_registers.sv
src/riscv_perf_counters.sv
src/riscv_debug_unit.sv
src/riscv_csr_subsystem.sv
bench/riscv_csr_subsystem_properties.sv
bench/riscv_csr_subsystem_tb.sv

//--- Makefile
TOP = riscv_csr_subsystem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f riscv_csr_subsystem.f --top-module riscv_csr_subsystem
	verilator --lint-only --timing --assert -f riscv_csr_subsystem.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f riscv_csr_subsystem.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
